// File: board_pkg.sv
////////////////////////////////////////////////////////////////////////////
// board pin definitions for the precision-meter front-end
// widths and bit positions of the 29-bit conditioning vector, plus the
// downstream SPI channel count and chip-select polarities
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package board_pkg;

  // conditioning vector size and group widths
  localparam int cond_bits   = 29;
  // three address bits plus enable
  localparam int amux_bits   = 4;
  localparam int mon_bits    = 8;
  localparam int adc_sw_bits = 4;

  // bit positions, counted from bit 0 upward
  localparam int azmux_lsb         = 0;
  localparam int himux_lsb         = 4;
  localparam int himux2_lsb        = 8;
  localparam int pc_sw_bit         = 12;
  localparam int led_bit           = 13;
  localparam int mon_lsb           = 14;
  localparam int adc_sw_lsb        = 22;
  localparam int cmpr_latch_bit    = 26;
  localparam int meas_complete_bit = 27;
  localparam int spi_interrupt_bit = 28;

  // downstream spi ports behind the second chip select
  localparam int spi_channels = 8;
  // active cs level per channel, the 4094 strobe on channel 0 goes high
  localparam logic [spi_channels-1:0] chan_cs_active = 8'b0000_0001;

  typedef logic [cond_bits-1:0] cond_t;

endpackage

`default_nettype wire

// File: regmap_pkg.sv
////////////////////////////////////////////////////////////////////////////
// register map of the MCU SPI slave
// frame layout, register addresses and output mode codes
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package regmap_pkg;

  // frame is an 8-bit command followed by a 32-bit data word, msb first
  localparam int cmd_bits      = 8;
  localparam int data_bits     = 32;
  localparam int frame_bits    = cmd_bits + data_bits;
  // command msb set means read, the low seven bits are the address
  localparam int read_flag_bit = 7;

  typedef logic [data_bits-1:0] reg_word_t;

  // register addresses
  localparam logic [cmd_bits-2:0] addr_scratch = 7'd1;
  localparam logic [cmd_bits-2:0] addr_spi_mux = 7'd2;
  localparam logic [cmd_bits-2:0] addr_mode    = 7'd3;
  localparam logic [cmd_bits-2:0] addr_direct  = 7'd4;

  // conditioning source select
  localparam int mode_bits = 3;

  typedef logic [mode_bits-1:0] mode_t;

  // codes 4 to 6 are unassigned and give zeros
  localparam mode_t mode_zero        = 3'd0;
  localparam mode_t mode_ones        = 3'd1;
  localparam mode_t mode_pattern     = 3'd2;
  localparam mode_t mode_direct      = 3'd3;
  localparam mode_t mode_pattern_alt = 3'd7;

endpackage

`default_nettype wire

// File: spi_frame_shifter.sv
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 slave frame shifter, oversampled in the clk domain
// shifts in command and data, strobes full-length writes at deselect and
// shifts out read data on falling sck edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module spi_frame_shifter
  import regmap_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic                spi_clk,
  input  logic                spi_cs,
  input  logic                spi_mosi,
  input  reg_word_t           rd_data,
  output logic                wr_strobe,
  output logic [cmd_bits-2:0] wr_addr,
  output reg_word_t           wr_data,
  output logic [cmd_bits-2:0] rd_addr,
  output logic                dout
);

  // counter saturates one past a full frame so long frames are rejected
  localparam int cnt_bits = $clog2(frame_bits + 2);

  logic [2:0]          sck_sync;
  logic [2:0]          cs_sync;
  logic [1:0]          mosi_sync;
  logic                sck_rise;
  logic                sck_fall;
  logic                cs_rise;
  logic                cs_active;
  logic                cmd_done;
  logic [cmd_bits-1:0] cmd_word;
  logic [cnt_bits-1:0] bit_cnt;
  logic                cmd_rd;
  logic [cmd_bits-2:0] cmd_addr;
  logic                load_pending;
  logic                tx_active;
  reg_word_t           shift_in;
  reg_word_t           tx_shift;

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronisers, third stage of sck and cs only for edge detection

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[1:0], spi_clk};
      cs_sync   <= {cs_sync[1:0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_active = ~cs_sync[1];

  // eighth rising edge completes the command byte
  assign cmd_done = cs_active & sck_rise & (bit_cnt == cnt_bits'(cmd_bits - 1));
  assign cmd_word = {shift_in[cmd_bits-2:0], mosi_sync[1]};

  ////////////////////////////////////////////////////////////////////////////
  // frame control

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt      <= '0;
      cmd_rd       <= 1'b0;
      cmd_addr     <= '0;
      load_pending <= 1'b0;
      tx_active    <= 1'b0;
      wr_strobe    <= 1'b0;
    end
    else
    begin
      if (!cs_active)
        bit_cnt <= '0;
      else if (sck_rise && bit_cnt != cnt_bits'(frame_bits + 1))
        bit_cnt <= bit_cnt + 1'b1;

      if (cmd_done)
      begin
        cmd_rd   <= cmd_word[read_flag_bit];
        cmd_addr <= cmd_word[cmd_bits-2:0];
      end

      // rd_data follows the new rd_addr one cycle after the command
      load_pending <= cmd_done & cmd_word[read_flag_bit];

      if (!cs_active)
        tx_active <= 1'b0;
      else if (load_pending)
        tx_active <= 1'b1;

      // only an exact 40-bit write frame commits
      wr_strobe <= cs_rise & ~cmd_rd & (bit_cnt == cnt_bits'(frame_bits));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data shifters

  always_ff @(posedge clk)
  begin
    if (cs_active && sck_rise)
      shift_in <= {shift_in[data_bits-2:0], mosi_sync[1]};

    // msb goes out first, the falling edge after the command byte is skipped
    if (load_pending)
      tx_shift <= rd_data;
    else if (tx_active && sck_fall && bit_cnt > cnt_bits'(cmd_bits))
      tx_shift <= {tx_shift[data_bits-2:0], 1'b0};
  end

  assign wr_addr = cmd_addr;
  assign rd_addr = cmd_addr;
  assign wr_data = shift_in;

  // raw cs drops the line at once, before the synchroniser catches up
  assign dout = tx_active & ~spi_cs & tx_shift[data_bits-1];

endmodule

`default_nettype wire

// File: control_registers.sv
////////////////////////////////////////////////////////////////////////////
// control register file behind the first chip select
// scratch, channel enable, mode and direct-drive registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module control_registers
  import regmap_pkg::*;
  import board_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    wr_strobe,
  input  logic [cmd_bits-2:0]     wr_addr,
  input  reg_word_t               wr_data,
  input  logic [cmd_bits-2:0]     rd_addr,
  output reg_word_t               rd_data,
  output logic [spi_channels-1:0] chan_enable,
  output mode_t                   mode,
  output cond_t                   direct
);

  reg_word_t scratch;

  ////////////////////////////////////////////////////////////////////////////
  // write side, fields keep only their own width

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      scratch     <= '0;
      chan_enable <= '0;
      mode        <= mode_zero;
      direct      <= '0;
    end
    else if (wr_strobe)
    begin
      case (wr_addr)
        addr_scratch: scratch     <= wr_data;
        addr_spi_mux: chan_enable <= wr_data[spi_channels-1:0];
        addr_mode:    mode        <= wr_data[mode_bits-1:0];
        addr_direct:  direct      <= wr_data[cond_bits-1:0];
        // unimplemented address, write dropped
        default:      ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side, zero-extended fields

  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      addr_scratch: rd_data                   = scratch;
      addr_spi_mux: rd_data[spi_channels-1:0] = chan_enable;
      addr_mode:    rd_data[mode_bits-1:0]    = mode;
      addr_direct:  rd_data[cond_bits-1:0]    = direct;
      // anything else reads as zero
      default:      rd_data                   = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: spi_port_router.sv
////////////////////////////////////////////////////////////////////////////
// SPI port router behind the second chip select
// fans sck and mosi out to enabled channels and muxes miso back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module spi_port_router
  import board_pkg::*;
(
  input  logic                    spi_cs2,
  input  logic                    spi_clk,
  input  logic                    spi_mosi,
  input  logic                    reg_dout,
  input  logic [spi_channels-1:0] chan_enable,
  input  logic [spi_channels-1:0] chan_miso,
  output logic [spi_channels-1:0] chan_cs,
  output logic [spi_channels-1:0] chan_clk,
  output logic [spi_channels-1:0] chan_mosi,
  output logic                    spi_miso
);

  // channels taking part in the current transfer
  logic [spi_channels-1:0] chan_sel;

  assign chan_sel = chan_enable & {spi_channels{~spi_cs2}};

  // idle channels park clk and mosi low
  assign chan_clk  = chan_sel & {spi_channels{spi_clk}};
  assign chan_mosi = chan_sel & {spi_channels{spi_mosi}};

  // per-channel polarity, active level when selected, else its inverse
  assign chan_cs = (chan_sel & chan_cs_active) | (~chan_sel & ~chan_cs_active);

  // register file drives miso unless the router is selected
  assign spi_miso = spi_cs2 ? reg_dout : |(chan_miso & chan_enable);

endmodule

`default_nettype wire

// File: test_pattern_gen.sv
////////////////////////////////////////////////////////////////////////////
// free-running conditioning test pattern, toggles every output pin
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module test_pattern_gen
  import board_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  output cond_t pattern
);

  // plain binary count, wraps at 2**29
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      pattern <= '0;
    else
      pattern <= pattern + 1'b1;
  end

endmodule

`default_nettype wire

// File: output_mode_select.sv
////////////////////////////////////////////////////////////////////////////
// conditioning output selector
// picks zeros, ones, test pattern or direct register by mode, registers
// the vector and splits it into the named board pins
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module output_mode_select
  import board_pkg::*;
  import regmap_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  mode_t                  mode,
  input  cond_t                  direct,
  input  cond_t                  pattern,
  output logic [amux_bits-1:0]   azmux,
  output logic [amux_bits-1:0]   himux,
  output logic [amux_bits-1:0]   himux2,
  output logic                   pc_sw,
  output logic                   led0,
  output logic [mon_bits-1:0]    monitor,
  output logic [adc_sw_bits-1:0] adc_sw,
  output logic                   cmpr_latch,
  output logic                   meas_complete,
  output logic                   spi_interrupt
);

  cond_t cond_next;
  cond_t cond_q;

  always_comb
  begin
    case (mode)
      mode_zero:        cond_next = '0;
      mode_ones:        cond_next = '1;
      mode_pattern:     cond_next = pattern;
      mode_pattern_alt: cond_next = pattern;
      mode_direct:      cond_next = direct;
      // spare codes hold everything off
      default:          cond_next = '0;
    endcase
  end

  // one register stage keeps the pins glitch free
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      cond_q <= '0;
    else
      cond_q <= cond_next;
  end

  ////////////////////////////////////////////////////////////////////////////
  // pin split, mux groups are {en, a2, a1, a0}

  assign azmux         = cond_q[azmux_lsb +: amux_bits];
  assign himux         = cond_q[himux_lsb +: amux_bits];
  assign himux2        = cond_q[himux2_lsb +: amux_bits];
  assign pc_sw         = cond_q[pc_sw_bit];
  assign led0          = cond_q[led_bit];
  assign monitor       = cond_q[mon_lsb +: mon_bits];
  assign adc_sw        = cond_q[adc_sw_lsb +: adc_sw_bits];
  assign cmpr_latch    = cond_q[cmpr_latch_bit];
  assign meas_complete = cond_q[meas_complete_bit];
  assign spi_interrupt = cond_q[spi_interrupt_bit];

endmodule

`default_nettype wire

// File: frontend_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// precision-meter front-end control core
// MCU SPI slave with register file, downstream SPI port router and the
// mode-selected conditioning outputs
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frontend_ctrl
  import board_pkg::*;
  import regmap_pkg::*;
(
  input  logic                    clk,
  input  logic                    arst_n,
  // mcu spi, cs selects registers and cs2 the router
  input  logic                    spi_clk,
  input  logic                    spi_cs,
  input  logic                    spi_cs2,
  input  logic                    spi_mosi,
  output logic                    spi_miso,
  // downstream spi channels, channel 0 is the 4094 chain
  output logic [spi_channels-1:0] chan_cs,
  output logic [spi_channels-1:0] chan_clk,
  output logic [spi_channels-1:0] chan_mosi,
  input  logic [spi_channels-1:0] chan_miso,
  // conditioning pins
  output logic [amux_bits-1:0]    azmux,
  output logic [amux_bits-1:0]    himux,
  output logic [amux_bits-1:0]    himux2,
  output logic                    pc_sw,
  output logic                    led0,
  output logic [mon_bits-1:0]     monitor,
  output logic [adc_sw_bits-1:0]  adc_sw,
  output logic                    cmpr_latch,
  output logic                    meas_complete,
  output logic                    spi_interrupt
);

  logic                    wr_strobe;
  logic [cmd_bits-2:0]     wr_addr;
  reg_word_t               wr_data;
  logic [cmd_bits-2:0]     rd_addr;
  reg_word_t               rd_data;
  logic                    reg_dout;
  logic [spi_channels-1:0] chan_enable;
  mode_t                   mode;
  cond_t                   direct;
  cond_t                   pattern;

  ////////////////////////////////////////////////////////////////////////////
  // register path

  spi_frame_shifter i_spi_frame_shifter (
    .clk       (clk),
    .arst_n    (arst_n),
    .spi_clk   (spi_clk),
    .spi_cs    (spi_cs),
    .spi_mosi  (spi_mosi),
    .rd_data   (rd_data),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .dout      (reg_dout)
  );

  control_registers i_control_registers (
    .clk         (clk),
    .arst_n      (arst_n),
    .wr_strobe   (wr_strobe),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .chan_enable (chan_enable),
    .mode        (mode),
    .direct      (direct)
  );

  // raw pins, no clk latency through the router
  spi_port_router i_spi_port_router (
    .spi_cs2     (spi_cs2),
    .spi_clk     (spi_clk),
    .spi_mosi    (spi_mosi),
    .reg_dout    (reg_dout),
    .chan_enable (chan_enable),
    .chan_miso   (chan_miso),
    .chan_cs     (chan_cs),
    .chan_clk    (chan_clk),
    .chan_mosi   (chan_mosi),
    .spi_miso    (spi_miso)
  );

  ////////////////////////////////////////////////////////////////////////////
  // conditioning outputs

  test_pattern_gen i_test_pattern_gen (
    .clk     (clk),
    .arst_n  (arst_n),
    .pattern (pattern)
  );

  output_mode_select i_output_mode_select (
    .clk           (clk),
    .arst_n        (arst_n),
    .mode          (mode),
    .direct        (direct),
    .pattern       (pattern),
    .azmux         (azmux),
    .himux         (himux),
    .himux2        (himux2),
    .pc_sw         (pc_sw),
    .led0          (led0),
    .monitor       (monitor),
    .adc_sw        (adc_sw),
    .cmpr_latch    (cmpr_latch),
    .meas_complete (meas_complete),
    .spi_interrupt (spi_interrupt)
  );

endmodule

`default_nettype wire

// File: frontend_ctrl_chk.sv
////////////////////////////////////////////////////////////////////////////
// bound assertions on the front-end control core
// router idle levels, miso parking and conditioning pins held in reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frontend_ctrl_chk
  import board_pkg::*;
(
  input logic                    clk,
  input logic                    arst_n,
  input logic                    spi_cs,
  input logic                    spi_cs2,
  input logic                    spi_miso,
  input logic [spi_channels-1:0] chan_cs,
  input logic [spi_channels-1:0] chan_clk,
  input logic [amux_bits-1:0]    azmux,
  input logic [amux_bits-1:0]    himux,
  input logic [amux_bits-1:0]    himux2,
  input logic                    pc_sw,
  input logic                    led0,
  input logic [mon_bits-1:0]     monitor,
  input logic [adc_sw_bits-1:0]  adc_sw,
  input logic                    cmpr_latch,
  input logic                    meas_complete,
  input logic                    spi_interrupt
);

  // any conditioning pin high
  logic cond_any;

  assign cond_any = |{azmux, himux, himux2, pc_sw, led0, monitor, adc_sw,
                      cmpr_latch, meas_complete, spi_interrupt};

  // deselected router parks every channel
  router_idle_a : assert property (@(posedge clk) disable iff (!arst_n)
    spi_cs2 |-> (chan_cs == ~chan_cs_active) && (chan_clk == '0))
    else $error("router channel driven while spi_cs2 is high");

  miso_parked_a : assert property (@(posedge clk) (spi_cs && spi_cs2) |-> !spi_miso)
    else $error("spi_miso high with both selects inactive");

  // first reset edge skipped, flops take reset there
  reset_pins_a : assert property (@(posedge clk) (!arst_n && $past(!arst_n)) |-> !cond_any)
    else $error("conditioning pin high during reset");

endmodule

bind frontend_ctrl frontend_ctrl_chk i_frontend_ctrl_chk (
  .clk           (clk),
  .arst_n        (arst_n),
  .spi_cs        (spi_cs),
  .spi_cs2       (spi_cs2),
  .spi_miso      (spi_miso),
  .chan_cs       (chan_cs),
  .chan_clk      (chan_clk),
  .azmux         (azmux),
  .himux         (himux),
  .himux2        (himux2),
  .pc_sw         (pc_sw),
  .led0          (led0),
  .monitor       (monitor),
  .adc_sw        (adc_sw),
  .cmpr_latch    (cmpr_latch),
  .meas_complete (meas_complete),
  .spi_interrupt (spi_interrupt)
);

`default_nettype wire

// File: frontend_ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the front-end control core
// random SPI register traffic, output modes and port router, all checked
// against a register model kept here
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module frontend_ctrl_tb
  import board_pkg::*;
  import regmap_pkg::*;
();

  localparam int clk_period  = 40;
  localparam int drive_delay = 2;
  // sck half period in clk cycles, well above the synchroniser delay
  localparam int half_clks   = 6;
  localparam int reg_ops     = 24;
  localparam int short_runs  = 4;
  localparam int router_runs = 8;
  // clk cycles per frame, idle gap and select setup included
  localparam int frame_clks  = (2 * frame_bits + 2) * half_clks + 4;
  localparam int planned_frames = 2 * reg_ops + 2 * short_runs + 12 + 2 + 2 * router_runs;
  localparam int watchdog_ns = (planned_frames + 10) * frame_clks * clk_period;

  logic                    clk;
  logic                    arst_n;
  logic                    spi_clk;
  logic                    spi_cs;
  logic                    spi_cs2;
  logic                    spi_mosi;
  logic                    spi_miso;
  logic [spi_channels-1:0] chan_cs;
  logic [spi_channels-1:0] chan_clk;
  logic [spi_channels-1:0] chan_mosi;
  logic [spi_channels-1:0] chan_miso;
  logic [amux_bits-1:0]    azmux;
  logic [amux_bits-1:0]    himux;
  logic [amux_bits-1:0]    himux2;
  logic                    pc_sw;
  logic                    led0;
  logic [mon_bits-1:0]     monitor;
  logic [adc_sw_bits-1:0]  adc_sw;
  logic                    cmpr_latch;
  logic                    meas_complete;
  logic                    spi_interrupt;

  // register model
  reg_word_t               m_scratch;
  logic [spi_channels-1:0] m_chan_en;
  mode_t                   m_mode;
  cond_t                   m_direct;

  int checks;
  int errors;
  bit verdict_printed;

  frontend_ctrl i_frontend_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .spi_clk       (spi_clk),
    .spi_cs        (spi_cs),
    .spi_cs2       (spi_cs2),
    .spi_mosi      (spi_mosi),
    .spi_miso      (spi_miso),
    .chan_cs       (chan_cs),
    .chan_clk      (chan_clk),
    .chan_mosi     (chan_mosi),
    .chan_miso     (chan_miso),
    .azmux         (azmux),
    .himux         (himux),
    .himux2        (himux2),
    .pc_sw         (pc_sw),
    .led0          (led0),
    .monitor       (monitor),
    .adc_sw        (adc_sw),
    .cmpr_latch    (cmpr_latch),
    .meas_complete (meas_complete),
    .spi_interrupt (spi_interrupt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired at %0t, the tests did not finish in time", $time);
    $display("checks: %0d  errors: %0d", checks, errors);
    verdict_printed = 1'b1;
    $display("Test failed");
    $finish;
  end

  // a run stopped by a failed assertion gets its verdict here
  final
  begin
    if (!verdict_printed)
      $display("Test failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, name, actual, expected);
    end
  endtask

  // n rising edges, then the drive offset
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #(drive_delay);
  endtask

  // named pins folded back into the conditioning vector
  function automatic cond_t pins_vector();
    cond_t v;
    v = '0;
    v[azmux_lsb +: amux_bits]     = azmux;
    v[himux_lsb +: amux_bits]     = himux;
    v[himux2_lsb +: amux_bits]    = himux2;
    v[pc_sw_bit]                  = pc_sw;
    v[led_bit]                    = led0;
    v[mon_lsb +: mon_bits]        = monitor;
    v[adc_sw_lsb +: adc_sw_bits]  = adc_sw;
    v[cmpr_latch_bit]             = cmpr_latch;
    v[meas_complete_bit]          = meas_complete;
    v[spi_interrupt_bit]          = spi_interrupt;
    return v;
  endfunction

  // fields read back zero-extended, other addresses read zero
  function automatic reg_word_t model_read(input logic [6:0] addr);
    reg_word_t v;
    v = '0;
    if (addr == addr_scratch)
      v = m_scratch;
    else if (addr == addr_spi_mux)
      v[spi_channels-1:0] = m_chan_en;
    else if (addr == addr_mode)
      v[mode_bits-1:0] = m_mode;
    else if (addr == addr_direct)
      v[cond_bits-1:0] = m_direct;
    return v;
  endfunction

  task automatic model_write(input logic [6:0] addr, input reg_word_t data);
    case (addr)
      addr_scratch: m_scratch = data;
      addr_spi_mux: m_chan_en = data[spi_channels-1:0];
      addr_mode:    m_mode    = data[mode_bits-1:0];
      addr_direct:  m_direct  = data[cond_bits-1:0];
      default:      ;
    endcase
  endtask

  // mode 0 frame on the first select, nbits long, miso of data bits in rd
  task automatic spi_frame(input logic [7:0] cmd, input reg_word_t data, input int nbits,
                           output reg_word_t rd);
    logic [frame_bits-1:0] frame;
    frame = {cmd, data};
    rd = '0;
    // idle gap so back to back frames see cs high
    step(4);
    spi_cs = 1'b0;
    step(half_clks);
    for (int i = 0; i < nbits; i++)
    begin
      spi_clk  = 1'b0;
      spi_mosi = frame[frame_bits-1-i];
      step(half_clks);
      // sampled just before the rising edge
      if (i >= cmd_bits)
        rd = {rd[data_bits-2:0], spi_miso};
      spi_clk = 1'b1;
      step(half_clks);
    end
    spi_clk  = 1'b0;
    spi_mosi = 1'b0;
    step(half_clks);
    spi_cs = 1'b1;
  endtask

  task automatic reg_write(input logic [6:0] addr, input reg_word_t data);
    reg_word_t ignored;
    spi_frame({1'b0, addr}, data, frame_bits, ignored);
    model_write(addr, data);
  endtask

  task automatic reg_read_check(input logic [6:0] addr);
    reg_word_t rd;
    spi_frame({1'b1, addr}, '0, frame_bits, rd);
    check_value($sformatf("spi_miso read of addr %0d", addr), rd, model_read(addr));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [6:0]              addr;
    reg_word_t               data;
    cond_t                   prev;
    cond_t                   cur;
    cond_t                   expect_vec;
    logic [spi_channels-1:0] en;
    logic [spi_channels-1:0] exp_cs;
    logic [spi_channels-1:0] idle_cs;
    logic                    exp_miso;
    mode_t                   static_modes [6] = '{mode_zero, mode_ones, mode_direct,
                                                  3'd4, 3'd5, 3'd6};
    mode_t                   pattern_modes [2] = '{mode_pattern, mode_pattern_alt};

    void'($urandom(49));
    checks          = 0;
    errors          = 0;
    verdict_printed = 1'b0;
    arst_n    = 1'b0;
    spi_clk   = 1'b0;
    spi_cs    = 1'b1;
    spi_cs2   = 1'b1;
    spi_mosi  = 1'b0;
    chan_miso = '0;
    m_scratch = '0;
    m_chan_en = '0;
    m_mode    = mode_zero;
    m_direct  = '0;
    idle_cs   = ~chan_cs_active;

    repeat (10) @(posedge clk);
    #(drive_delay);
    arst_n = 1'b1;
    step(2);

    // reset state
    check_value("conditioning pins after reset", 32'(pins_vector()), 32'd0);
    check_value("chan_cs after reset", 32'(chan_cs), 32'(idle_cs));
    check_value("spi_miso after reset", 32'(spi_miso), 32'd0);

    // write then read back, low addresses in turn, then anywhere
    for (int i = 0; i < reg_ops; i++)
    begin
      if (i < 16)
        addr = 7'(i % 8);
      else
        addr = 7'($urandom);
      data = $urandom;
      reg_write(addr, data);
      reg_read_check(addr);
    end

    // frames cut short before 40 bits leave the model untouched
    for (int i = 0; i < short_runs; i++)
    begin
      addr = 7'(1 + $urandom % 4);
      spi_frame({1'b0, addr}, $urandom, 8 + int'($urandom % 32), data);
      reg_read_check(addr);
    end

    // static modes, upper mode bits random and dropped
    foreach (static_modes[k])
    begin
      reg_write(addr_direct, $urandom);
      reg_write(addr_mode, ($urandom & ~32'h7) | 32'(static_modes[k]));
      step(10);
      if (m_mode == mode_ones)
        expect_vec = '1;
      else if (m_mode == mode_direct)
        expect_vec = m_direct;
      else
        expect_vec = '0;
      check_value($sformatf("conditioning pins in mode %0d", m_mode),
                  32'(pins_vector()), 32'(expect_vec));
    end

    // pattern modes count up by one per clk, wrapping at 29 bits
    foreach (pattern_modes[k])
    begin
      reg_write(addr_mode, 32'(pattern_modes[k]));
      step(10);
      prev = pins_vector();
      for (int c = 0; c < 32; c++)
      begin
        step(1);
        cur        = pins_vector();
        expect_vec = prev + 1'b1;
        check_value("conditioning pattern step", 32'(cur), 32'(expect_vec));
        prev = cur;
      end
    end

    // port router behind the second select
    for (int r = 0; r < router_runs; r++)
    begin
      reg_write(addr_spi_mux, $urandom);
      // new enable mask lands a few clk cycles after the select rises
      step(10);
      en = m_chan_en;
      for (int ch = 0; ch < spi_channels; ch++)
        exp_cs[ch] = en[ch] ? chan_cs_active[ch] : ~chan_cs_active[ch];
      spi_cs2 = 1'b0;
      for (int b = 0; b < 16; b++)
      begin
        spi_clk   = 1'($urandom);
        spi_mosi  = 1'($urandom);
        chan_miso = 8'($urandom);
        // any enabled channel driving miso high pulls the line high
        exp_miso = 1'b0;
        for (int ch = 0; ch < spi_channels; ch++)
          if (en[ch] && chan_miso[ch])
            exp_miso = 1'b1;
        // router is combinational, let it settle
        #1;
        check_value("chan_cs", 32'(chan_cs), 32'(exp_cs));
        check_value("chan_clk", 32'(chan_clk), spi_clk ? 32'(en) : 32'd0);
        check_value("chan_mosi", 32'(chan_mosi), spi_mosi ? 32'(en) : 32'd0);
        check_value("spi_miso", 32'(spi_miso), 32'(exp_miso));
        step(1);
      end
      spi_clk  = 1'b0;
      spi_mosi = 1'b0;
      spi_cs2  = 1'b1;
      #1;
      check_value("chan_cs idle", 32'(chan_cs), 32'(idle_cs));
      check_value("chan_clk idle", 32'(chan_clk), 32'd0);
      check_value("chan_mosi idle", 32'(chan_mosi), 32'd0);
      check_value("spi_miso idle", 32'(spi_miso), 32'd0);
      step(1);
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    verdict_printed = 1'b1;
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: frontend_ctrl.f
board_pkg.sv
regmap_pkg.sv
spi_frame_shifter.sv
control_registers.sv
spi_port_router.sv
test_pattern_gen.sv
output_mode_select.sv
frontend_ctrl.sv
frontend_ctrl_chk.sv
frontend_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the front-end control core testbench

TOP := frontend_ctrl_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): frontend_ctrl.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f frontend_ctrl.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir
